// File: include/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

`define ICACHE_ADDR_WIDTH 32   // CPU and memory byte address
`define ICACHE_OFFSET_BITS 5   // 32-byte lines
`define ICACHE_INDEX_BITS 3    // 8 sets, direct mapped
`define ICACHE_WORD_WIDTH 32   // Instruction word

// Derived sizes
`define ICACHE_TAG_BITS (`ICACHE_ADDR_WIDTH - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)
`define ICACHE_LINE_WIDTH (8 << `ICACHE_OFFSET_BITS)
`define ICACHE_NUM_SETS (1 << `ICACHE_INDEX_BITS)

`define PMEM_MIN_LATENCY 1     // Cycles from pmem_read to pmem_resp, lower bound
`define PMEM_MAX_LATENCY 8     // Upper bound, also sizes the watchdog

`endif

// File: rtl/icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_WIDTH-1:0] addr_t;    // Byte address
  typedef logic [`ICACHE_WORD_WIDTH-1:0] word_t;    // One instruction
  typedef logic [`ICACHE_LINE_WIDTH-1:0] line_t;    // Full cache line
  typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;
  typedef logic [`ICACHE_OFFSET_BITS-1:0] offset_t;

  // Fetch address split into its cache fields, tag in the top bits
  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } addr_fields_t;

  // Write strobes from the controller to the arrays
  typedef struct packed {
    logic tag_load;
    logic valid_load;
    logic data_load;
  } ctrl_bundle_t;

  typedef enum logic [0:0] {
    check_hit,  // Idle or answering hits
    read_mem    // Waiting on a line fill
  } icache_state_t;

endpackage

`default_nettype wire

// File: rtl/icache_control.sv
`timescale 1ns/1ns
`default_nettype none

module icache_control
  import icache_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  // CPU side
  input  logic         mem_read,
  output logic         mem_resp,

  // Physical memory side
  input  logic         pmem_resp,
  output logic         pmem_read,

  // Datapath
  input  logic         hit,
  output ctrl_bundle_t ctrl
);

  icache_state_t state;
  icache_state_t next_state;

  // Outputs depend on state and inputs only
  always_comb begin
    mem_resp  = 1'b0;
    pmem_read = 1'b0;
    ctrl      = '0;

    case (state)
      check_hit: begin
        if (mem_read && hit) begin
          mem_resp = 1'b1;          // Same-cycle hit answer
        end
      end

      read_mem: begin
        pmem_read = 1'b1;           // Level request, held until answered
        if (pmem_resp) begin
          ctrl.tag_load   = 1'b1;   // Line arrives this edge
          ctrl.valid_load = 1'b1;
          ctrl.data_load  = 1'b1;
        end
      end
    endcase
  end

  always_comb begin
    next_state = state;

    case (state)
      check_hit: begin
        if (mem_read && !hit) begin
          next_state = read_mem;    // Miss, go fetch the line
        end
      end

      read_mem: begin
        if (pmem_resp) begin
          next_state = check_hit;   // Filled line hits on the next cycle
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= check_hit;
    end else begin
      state <= next_state;
    end
  end

  // A response and a line request never overlap on the two buses
  a_resp_excl_fill: assert property (
    @(posedge clk) disable iff (rst)
    !(mem_resp && pmem_read)
  ) else $error("mem_resp and pmem_read high in the same cycle");

  // Only a pending CPU fetch is answered
  a_resp_needs_read: assert property (
    @(posedge clk) disable iff (rst)
    mem_resp |-> mem_read
  ) else $error("mem_resp without mem_read");

endmodule

`default_nettype wire

// File: rtl/icache_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_datapath
  import icache_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  // CPU address in, selected word out
  input  addr_t        mem_address,
  output word_t        mem_rdata,

  // Controller
  input  ctrl_bundle_t ctrl,
  output logic         hit,

  // Physical memory
  input  line_t        pmem_rdata,
  output addr_t        pmem_address
);

  localparam int WORD_SEL_LSB  = $clog2(`ICACHE_WORD_WIDTH / 8);
  localparam int WORD_SEL_BITS = `ICACHE_OFFSET_BITS - WORD_SEL_LSB;

  addr_fields_t fields;        // Decoded fetch address
  addr_fields_t line_fields;   // Same address with offset cleared

  // Storage, one entry per set
  tag_t                      tag_array   [`ICACHE_NUM_SETS];
  line_t                     data_array  [`ICACHE_NUM_SETS];
  logic [`ICACHE_NUM_SETS-1:0] valid_array;

  // Indexed entry, read asynchronously
  tag_t                      stored_tag;
  line_t                     stored_line;
  logic                      stored_valid;

  logic [WORD_SEL_BITS-1:0]  word_sel;

  assign fields = addr_fields_t'(mem_address);

  assign stored_tag   = tag_array[fields.index];
  assign stored_line  = data_array[fields.index];
  assign stored_valid = valid_array[fields.index];

  assign hit = stored_valid && (stored_tag == fields.tag);

  // Word within the line, byte bits dropped
  assign word_sel  = fields.offset[`ICACHE_OFFSET_BITS-1:WORD_SEL_LSB];
  assign mem_rdata = stored_line[word_sel * `ICACHE_WORD_WIDTH +: `ICACHE_WORD_WIDTH];

  // Memory always sees a line-aligned address
  always_comb begin
    line_fields        = fields;
    line_fields.offset = '0;
  end

  assign pmem_address = addr_t'(line_fields);

  always_ff @(posedge clk) begin
    if (ctrl.tag_load) begin
      tag_array[fields.index] <= fields.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.data_load) begin
      data_array[fields.index] <= pmem_rdata;   // Whole line in one write
    end
  end

  // Valid bits are the only state that reset touches
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_array <= '0;
    end else if (ctrl.valid_load) begin
      valid_array[fields.index] <= 1'b1;
    end
  end

  // Fills always write the whole set entry together
  a_fill_complete: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.data_load |-> (ctrl.tag_load && ctrl.valid_load)
  ) else $error("data_load without tag_load and valid_load");

  // Reset invalidates every set by the next cycle
  a_reset_clears_valid: assert property (
    @(posedge clk)
    rst |=> (valid_array == '0)
  ) else $error("valid bits not clear after reset");

  // With the CPU holding its address, a fill makes the next cycle a hit
  a_fill_then_hit: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.valid_load |=> hit
  ) else $error("no hit in the cycle after a line fill");

endmodule

`default_nettype wire

// File: rtl/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache
  import icache_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  // CPU fetch port
  input  logic  mem_read,
  input  addr_t mem_address,
  output logic  mem_resp,
  output word_t mem_rdata,

  // Physical memory port, one line per request
  output logic  pmem_read,
  output addr_t pmem_address,
  input  line_t pmem_rdata,
  input  logic  pmem_resp
);

  ctrl_bundle_t ctrl;   // Array write strobes
  logic         hit;    // Indexed set matches the fetch tag

  icache_control u_control (
    .clk       (clk),
    .rst       (rst),
    .mem_read  (mem_read),
    .mem_resp  (mem_resp),
    .pmem_resp (pmem_resp),
    .pmem_read (pmem_read),
    .hit       (hit),
    .ctrl      (ctrl)
  );

  icache_datapath u_datapath (
    .clk          (clk),
    .rst          (rst),
    .mem_address  (mem_address),
    .mem_rdata    (mem_rdata),
    .ctrl         (ctrl),
    .hit          (hit),
    .pmem_rdata   (pmem_rdata),
    .pmem_address (pmem_address)
  );

endmodule

`default_nettype wire

// File: test/pmem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module pmem_model
  import icache_pkg::*;
#(
  parameter integer SEED = 32'h512d
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  pmem_read,
  input  addr_t pmem_address,
  output line_t pmem_rdata,
  output logic  pmem_resp
);

  localparam int WORDS_PER_LINE = `ICACHE_LINE_WIDTH / `ICACHE_WORD_WIDTH;
  localparam int LATENCY_SPAN   = `PMEM_MAX_LATENCY - `PMEM_MIN_LATENCY + 1;

  integer      seed;
  logic [31:0] rnd;
  logic        busy;       // A request is being served
  int          wait_cnt;   // Cycles left before the answer

  // Word k of a line is the inverted byte address of that word
  function automatic line_t make_line(input addr_t line_addr);
    line_t line;
    int    k;
    begin
      line = '0;
      for (k = 0; k < WORDS_PER_LINE; k++) begin
        line[k*`ICACHE_WORD_WIDTH +: `ICACHE_WORD_WIDTH] = ~(line_addr + addr_t'(4 * k));
      end
      return line;
    end
  endfunction

  // Outputs change on the falling edge only
  initial begin
    seed       = SEED;
    busy       = 1'b0;
    wait_cnt   = 0;
    pmem_resp  = 1'b0;
    pmem_rdata = '0;
    forever begin
      @(negedge clk);
      if (rst) begin
        busy      = 1'b0;
        pmem_resp = 1'b0;
      end else if (pmem_resp) begin
        pmem_resp = 1'b0;   // One-cycle pulse
        busy      = 1'b0;
      end else if (pmem_read) begin
        if (!busy) begin
          rnd      = $random(seed);
          wait_cnt = `PMEM_MIN_LATENCY + int'(rnd % LATENCY_SPAN);
          busy     = 1'b1;
        end
        wait_cnt = wait_cnt - 1;
        if (wait_cnt == 0) begin
          pmem_rdata = make_line(pmem_address);
          pmem_resp  = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 10;
  localparam int RANDOM_FETCHES  = 2000;
  localparam int WATCHDOG_CYCLES =
    (RANDOM_FETCHES + 16) * (`PMEM_MAX_LATENCY + 4) + 3 * RESET_CYCLES + 500;

  localparam addr_t ADDR_A   = 32'h1234_5044;   // Set 2
  localparam addr_t ADDR_A2  = 32'h1234_504c;   // Same line as ADDR_A
  localparam addr_t ADDR_B   = 32'h00ab_c05c;   // Set 2, other tag
  localparam tag_t  TAG_BASE = 24'h0a5c00;      // Random tags come from a pool of 4

  logic  clk = 1'b0;
  logic  rst;
  logic  mem_read;
  addr_t mem_address;
  logic  mem_resp;
  word_t mem_rdata;
  logic  pmem_read;
  addr_t pmem_address;
  line_t pmem_rdata;
  logic  pmem_resp;

  integer seed = 32'h512d;
  integer word_errors = 0;
  integer addr_errors = 0;
  integer count_errors = 0;
  integer predicted_misses = 0;
  integer pmem_reads = 0;

  // Tag and valid state of the expected cache contents
  tag_t                        model_tag [`ICACHE_NUM_SETS];
  logic [`ICACHE_NUM_SETS-1:0] model_valid;

  always #(CLK_PERIOD / 2) clk = ~clk;

  icache u_icache (
    .clk          (clk),
    .rst          (rst),
    .mem_read     (mem_read),
    .mem_address  (mem_address),
    .mem_resp     (mem_resp),
    .mem_rdata    (mem_rdata),
    .pmem_read    (pmem_read),
    .pmem_address (pmem_address),
    .pmem_rdata   (pmem_rdata),
    .pmem_resp    (pmem_resp)
  );

  pmem_model u_pmem (
    .clk          (clk),
    .rst          (rst),
    .pmem_read    (pmem_read),
    .pmem_address (pmem_address),
    .pmem_rdata   (pmem_rdata),
    .pmem_resp    (pmem_resp)
  );

  always @(posedge clk) begin
    if (pmem_resp) pmem_reads <= pmem_reads + 1;   // Completed line reads
  end

  // Byte address with the offset bits forced to zero
  function automatic addr_t line_address(input addr_t a);
    return {a[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
  endfunction

  // Inverted address of the word, built from line base plus 4 per word
  function automatic word_t expected_word(input addr_t a);
    addr_t step;
    begin
      step = addr_t'(a[`ICACHE_OFFSET_BITS-1:2]) * 4;
      return ~(line_address(a) + step);
    end
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      word_errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      addr_errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input integer exp, input integer act);
    if (act !== exp) begin
      count_errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic apply_reset();
    rst         = 1'b1;
    mem_read    = 1'b0;
    model_valid = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
  endtask

  // One CPU fetch, held until mem_resp, checked against the model
  task automatic fetch(input addr_t addr, input string name, output integer fills);
    addr_fields_t f;
    logic         exp_hit;
    logic         addr_seen;
    integer       cycles;
    begin
      f         = addr;
      exp_hit   = model_valid[f.index] && (model_tag[f.index] == f.tag);
      fills     = 0;
      cycles    = 0;
      addr_seen = 1'b0;
      @(negedge clk);
      mem_read    = 1'b1;
      mem_address = addr;
      do begin
        @(posedge clk);
        cycles++;
        if (pmem_read && !addr_seen) begin
          check_addr({name, " pmem_address"}, line_address(addr), pmem_address);
          addr_seen = 1'b1;
        end
        if (pmem_resp) fills++;
      end while (!mem_resp);
      check_word({name, " mem_rdata"}, expected_word(addr), mem_rdata);
      check_count({name, " line fills"}, exp_hit ? 0 : 1, fills);
      if (exp_hit) begin
        check_count({name, " hit cycles"}, 1, cycles);   // Answer in the request cycle
      end else begin
        model_valid[f.index] = 1'b1;
        model_tag[f.index]   = f.tag;
        predicted_misses++;
      end
    end
  endtask

  initial begin
    addr_fields_t rf;
    addr_t        last_addr;
    logic [31:0]  rnd;
    integer       fills;
    integer       reads0;
    integer       misses0;
    mem_address = '0;
    last_addr   = ADDR_A;
    apply_reset();

    fetch(ADDR_A, "cold miss", fills);
    check_count("cold miss memory reads", 1, fills);
    fetch(ADDR_A2, "same line hit", fills);

    fetch(ADDR_B, "conflict B first", fills);
    fetch(ADDR_A, "conflict A", fills);
    fetch(ADDR_B, "conflict B", fills);
    check_count("conflict B refill", 1, fills);

    reads0  = pmem_reads;
    misses0 = predicted_misses;
    for (int i = 0; i < RANDOM_FETCHES; i++) begin
      rnd       = $random(seed);
      rf.tag    = TAG_BASE + tag_t'(rnd[1:0]);
      rf.index  = rnd[8 +: `ICACHE_INDEX_BITS];
      rf.offset = {rnd[16 +: `ICACHE_OFFSET_BITS-2], 2'b00};
      last_addr = rf;
      fetch(last_addr, "random fetch", fills);
      repeat (int'(rnd[30:29])) begin
        @(negedge clk);
        mem_read = 1'b0;                              // Idle gap
      end
    end
    check_count("random run memory reads", predicted_misses - misses0, pmem_reads - reads0);

    fetch(last_addr, "hit before reset", fills);
    @(negedge clk);
    apply_reset();
    fetch(last_addr, "refetch after reset", fills);
    check_count("refetch after reset memory reads", 1, fills);

    @(negedge clk);
    mem_read = 1'b0;
    repeat (2) @(negedge clk);
    $display("Errors: word %0d, address %0d, count %0d", word_errors, addr_errors, count_errors);
    if (word_errors + addr_errors + count_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Ends a run where the cache or memory stops answering
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: no end of test after %0d cycles, a fetch never got its response",
             WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
rtl/icache_pkg.sv
rtl/icache_control.sv
rtl/icache_datapath.sv
rtl/icache.sv
test/pmem_model.sv
test/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the icache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module icache_tb \
  -Mdir obj_dir -o icache_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/icache_tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
